/* design/fetch_unit.sv */
`timescale 1ns/10ps
`include "ifu_params.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 fifo_rst,
    input  logic                 redirect,
    input  logic [31:0]          redirect_pc,
    input  logic                 full,
    input  ifu_pkg::apb_rsp_t    apb_rsp,
    output ifu_pkg::apb_req_t    apb_req,
    output logic                 wr_en,
    output ifu_pkg::issue_slot_t wr0,
    output ifu_pkg::issue_slot_t wr1
);

    localparam logic [31:0] RESET_PC = `IFU_RESET_PC;

    ifu_pkg::fetch_state_e state;

    // next pair to fetch, 8-byte units
    logic [31:3] pc_q;
    // pair currently on the bus
    logic [31:3] pair_q;
    // 0 while fetching the low word, 1 for the high word
    logic        word_sel;
    // transfer in flight belongs to a stale stream
    logic        discard;
    // entry after an odd-word target, low word is dead
    logic        skip_first;
    logic [31:0] inst0_q;
    logic [31:0] inst1_q;
    logic        start;
    logic        xfer_done;

    // new pair only with room for two and no redirect this cycle
    assign start     = (state == ifu_pkg::fs_idle) && !full && !redirect;
    assign xfer_done = (state == ifu_pkg::fs_access) && apb_rsp.pready;

    // bus signals straight from the state, paddr fixed for the whole transfer
    assign apb_req = '{
        psel:    (state == ifu_pkg::fs_setup) || (state == ifu_pkg::fs_access),
        penable: (state == ifu_pkg::fs_access),
        paddr:   {pair_q, word_sel, 2'b00}
    };

    assign wr_en = (state == ifu_pkg::fs_push);
    assign wr0   = '{valid: !skip_first, pc: {pair_q, 3'b000}, inst: inst0_q};
    assign wr1   = '{valid: 1'b1, pc: {pair_q, 3'b100}, inst: inst1_q};

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            state      <= ifu_pkg::fs_idle;
            pc_q       <= RESET_PC[31:3];
            skip_first <= RESET_PC[2];
            word_sel   <= 1'b0;
            discard    <= 1'b0;
        end else begin
            // target taken at once
            // the bus side catches up below
            if (redirect) begin
                pc_q       <= redirect_pc[31:3];
                skip_first <= redirect_pc[2];
            end else if (state == ifu_pkg::fs_push) begin
                pc_q       <= pc_q + 1'b1;
                skip_first <= 1'b0;
            end

            case (state)
                ifu_pkg::fs_idle: begin
                    if (start) begin
                        state    <= ifu_pkg::fs_setup;
                        word_sel <= 1'b0;
                    end
                end
                ifu_pkg::fs_setup: begin
                    state <= ifu_pkg::fs_access;
                    // transfer already started, let it finish
                    if (redirect) begin
                        discard <= 1'b1;
                    end
                end
                ifu_pkg::fs_access: begin
                    if (apb_rsp.pready) begin
                        if (redirect || discard) begin
                            // stale pair, drop it and restart from pc_q
                            state    <= ifu_pkg::fs_idle;
                            discard  <= 1'b0;
                            word_sel <= 1'b0;
                        end else if (!word_sel) begin
                            state    <= ifu_pkg::fs_setup;
                            word_sel <= 1'b1;
                        end else begin
                            state <= ifu_pkg::fs_push;
                        end
                    end else if (redirect) begin
                        discard <= 1'b1;
                    end
                end
                ifu_pkg::fs_push: begin
                    // back to idle so full is seen after the write
                    state    <= ifu_pkg::fs_idle;
                    word_sel <= 1'b0;
                end
                default: begin
                    state <= ifu_pkg::fs_idle;
                end
            endcase
        end
    end

    // pair base sampled once per pair
    always_ff @(posedge clk) begin
        if (start) begin
            pair_q <= pc_q;
        end
    end

    // read data capture
    always_ff @(posedge clk) begin
        if (xfer_done && !word_sel) begin
            inst0_q <= apb_rsp.prdata;
        end
        if (xfer_done && word_sel) begin
            inst1_q <= apb_rsp.prdata;
        end
    end

endmodule

/* design/ifu_params.svh */
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// instruction queue entries
// any power of two from 4 up
`define IFU_FIFO_DEPTH 16

// queue pointer width, log2 of the depth
`define IFU_PTR_W 4

// boot vector, first pair fetched out of reset
`define IFU_RESET_PC 32'hbfc00000

`endif

/* design/ifu_pkg.sv */
package ifu_pkg;

    // apb read request from the fetch side
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic [31:0] paddr;
    } apb_req_t;

    // apb read response from instruction memory
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
    } apb_rsp_t;

    // one instruction with its address
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } issue_slot_t;

    typedef enum logic [1:0] {
        cls_other,
        cls_branch,
        cls_jump
    } inst_class_e;

    typedef enum logic [1:0] {
        fs_idle,
        fs_setup,
        fs_access,
        fs_push
    } fetch_state_e;

    // primary opcodes that change control flow
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_regimm  = 6'b000001,
        op_j       = 6'b000010,
        op_jal     = 6'b000011,
        op_beq     = 6'b000100,
        op_bne     = 6'b000101,
        op_blez    = 6'b000110,
        op_bgtz    = 6'b000111
    } opcode_e;

    // register jumps under the special opcode
    typedef enum logic [5:0] {
        fn_jr   = 6'b001000,
        fn_jalr = 6'b001001
    } funct_e;

    function automatic inst_class_e classify(input logic [31:0] inst);
        inst_class_e cls;
        cls = cls_other;
        case (inst[31:26])
            op_regimm, op_beq, op_bne, op_blez, op_bgtz: begin
                cls = cls_branch;
            end
            op_j, op_jal: begin
                cls = cls_jump;
            end
            op_special: begin
                // jr and jalr only, rest of special is alu work
                if (inst[5:0] == fn_jr || inst[5:0] == fn_jalr) begin
                    cls = cls_jump;
                end
            end
            default: begin
                cls = cls_other;
            end
        endcase
        return cls;
    endfunction

endpackage

/* design/ifu_top.sv */
`timescale 1ns/10ps

module ifu_top (
    input  logic                 clk,
    input  logic                 fifo_rst,
    input  ifu_pkg::apb_rsp_t    apb_rsp,
    input  logic                 d_ena,
    input  logic                 redirect,
    input  logic [31:0]          redirect_pc,
    output ifu_pkg::apb_req_t    apb_req,
    output ifu_pkg::issue_slot_t issue0,
    output ifu_pkg::issue_slot_t issue1,
    output logic                 in_delay_slot
);

    // fetch to queue
    logic                 wr_en;
    ifu_pkg::issue_slot_t wr0;
    ifu_pkg::issue_slot_t wr1;
    logic                 full;

    // queue to issue and back
    ifu_pkg::issue_slot_t head0;
    ifu_pkg::issue_slot_t head1;
    logic                 hold_active;
    logic                 rd_en1;
    logic                 rd_en2;
    logic                 delay_pending;

    fetch_unit u_fetch (
        .clk         (clk),
        .fifo_rst    (fifo_rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .full        (full),
        .apb_rsp     (apb_rsp),
        .apb_req     (apb_req),
        .wr_en       (wr_en),
        .wr0         (wr0),
        .wr1         (wr1)
    );

    inst_fifo u_fifo (
        .clk           (clk),
        .fifo_rst      (fifo_rst),
        .redirect      (redirect),
        .delay_pending (delay_pending),
        .wr_en         (wr_en),
        .wr0           (wr0),
        .wr1           (wr1),
        .rd_en1        (rd_en1),
        .rd_en2        (rd_en2),
        .head0         (head0),
        .head1         (head1),
        .hold_active   (hold_active),
        .full          (full)
    );

    issue_ctrl u_issue (
        .clk           (clk),
        .fifo_rst      (fifo_rst),
        .d_ena         (d_ena),
        .head0         (head0),
        .head1         (head1),
        .hold_active   (hold_active),
        .issue0        (issue0),
        .issue1        (issue1),
        .in_delay_slot (in_delay_slot),
        .rd_en1        (rd_en1),
        .rd_en2        (rd_en2),
        .delay_pending (delay_pending)
    );

endmodule

/* design/inst_fifo.sv */
`timescale 1ns/10ps
`include "ifu_params.svh"

module inst_fifo (
    input  logic                 clk,
    input  logic                 fifo_rst,
    input  logic                 redirect,
    input  logic                 delay_pending,
    input  logic                 wr_en,
    input  ifu_pkg::issue_slot_t wr0,
    input  ifu_pkg::issue_slot_t wr1,
    input  logic                 rd_en1,
    input  logic                 rd_en2,
    output ifu_pkg::issue_slot_t head0,
    output ifu_pkg::issue_slot_t head1,
    output logic                 hold_active,
    output logic                 full
);

    localparam int DEPTH = `IFU_FIFO_DEPTH;
    localparam int PW    = `IFU_PTR_W;

    logic [31:0]          mem_pc   [DEPTH];
    logic [31:0]          mem_inst [DEPTH];

    logic [PW-1:0]        wr_ptr;
    logic [PW-1:0]        rd_ptr;
    logic [PW-1:0]        wr_ptr_nx;
    logic [PW-1:0]        rd_ptr_nx;
    // one bit wider than the pointers to tell full from empty
    logic [PW:0]          count;
    logic [1:0]           n_wr;
    logic [1:0]           n_rd;

    // first valid write slot lands at wr_ptr
    ifu_pkg::issue_slot_t wr_first;
    logic                 wr_both;

    // delay-slot hold register
    logic                 hold_valid;
    logic [31:0]          hold_pc;
    logic [31:0]          hold_inst;
    logic                 capture;

    assign wr_ptr_nx = wr_ptr + 1'b1;
    assign rd_ptr_nx = rd_ptr + 1'b1;

    assign wr_first = wr0.valid ? wr0 : wr1;
    assign wr_both  = wr0.valid && wr1.valid;

    // entries added this cycle, odd-word pairs add one
    assign n_wr = wr_en ? ({1'b0, wr0.valid} + {1'b0, wr1.valid}) : 2'd0;
    // queue pops only when the hold register is empty
    assign n_rd = (rd_en1 && !hold_valid) ? (rd_en2 ? 2'd2 : 2'd1) : 2'd0;

    // fewer than two free entries
    assign full = (count > (PW + 1)'(DEPTH - 2));

    assign hold_active = hold_valid;

    // redirect with the delay slot still waiting at the head
    assign capture = redirect && delay_pending && !rd_en1;

    always_ff @(posedge clk) begin
        if (wr_en && wr_first.valid) begin
            mem_pc[wr_ptr]   <= wr_first.pc;
            mem_inst[wr_ptr] <= wr_first.inst;
        end
        if (wr_en && wr_both) begin
            mem_pc[wr_ptr_nx]   <= wr1.pc;
            mem_inst[wr_ptr_nx] <= wr1.inst;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (redirect) begin
            // stream flushed, writes at this edge are dropped too
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PW'(n_wr);
            rd_ptr <= rd_ptr + PW'(n_rd);
            count  <= count + (PW + 1)'(n_wr) - (PW + 1)'(n_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            hold_valid <= 1'b0;
        end else if (capture) begin
            // empty head leaves nothing to keep
            hold_valid <= head0.valid;
        end else if (rd_en1 || redirect) begin
            hold_valid <= 1'b0;
        end
    end

    // copies itself when already holding, head0 is the hold then
    always_ff @(posedge clk) begin
        if (capture) begin
            hold_pc   <= head0.pc;
            hold_inst <= head0.inst;
        end
    end

    // heads read straight from the buffer
    always_comb begin
        head0 = '0;
        head1 = '0;
        if (hold_valid) begin
            // held delay slot goes out alone
            head0 = '{valid: 1'b1, pc: hold_pc, inst: hold_inst};
        end else begin
            if (count != '0) begin
                head0 = '{valid: 1'b1, pc: mem_pc[rd_ptr], inst: mem_inst[rd_ptr]};
            end
            if (count > (PW + 1)'(1)) begin
                head1 = '{valid: 1'b1, pc: mem_pc[rd_ptr_nx], inst: mem_inst[rd_ptr_nx]};
            end
        end
    end

endmodule

/* design/issue_ctrl.sv */
`timescale 1ns/10ps

module issue_ctrl (
    input  logic                 clk,
    input  logic                 fifo_rst,
    input  logic                 d_ena,
    input  ifu_pkg::issue_slot_t head0,
    input  ifu_pkg::issue_slot_t head1,
    input  logic                 hold_active,
    output ifu_pkg::issue_slot_t issue0,
    output ifu_pkg::issue_slot_t issue1,
    output logic                 in_delay_slot,
    output logic                 rd_en1,
    output logic                 rd_en2,
    output logic                 delay_pending
);

    ifu_pkg::inst_class_e cls0;
    // head0 is a branch or jump
    logic                 is_cti;
    logic                 offer0;
    logic                 offer1;

    assign cls0   = ifu_pkg::classify(head0.inst);
    assign is_cti = (cls0 != ifu_pkg::cls_other);

    // a branch waits for its delay slot to be queued behind it
    // held delay slot has nothing behind it by design
    assign offer0 = head0.valid && (!is_cti || head1.valid || hold_active);

    // no pairing behind a branch, delay slot goes next as master
    assign offer1 = offer0 && head1.valid && !is_cti;

    assign issue0 = '{valid: offer0, pc: head0.pc, inst: head0.inst};
    assign issue1 = '{valid: offer1, pc: head1.pc, inst: head1.inst};

    // pops follow the decode handshake
    assign rd_en1 = offer0 && d_ena;
    assign rd_en2 = offer1 && d_ena;

    // set by a lone branch or jump
    // cleared by the next master that goes out
    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            delay_pending <= 1'b0;
            in_delay_slot <= 1'b0;
        end else if (rd_en1) begin
            delay_pending <= is_cti && !rd_en2;
            in_delay_slot <= is_cti && !rd_en2;
        end
    end

endmodule

/* flist.f */
+incdir+design
design/ifu_pkg.sv
design/fetch_unit.sv
design/inst_fifo.sv
design/issue_ctrl.sv
design/ifu_top.sv
tests/tb_ifu.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_ifu -o tb_ifu

sim_out=$(./obj_dir/tb_ifu)
echo "$sim_out"

if grep -qx "RESULT: PASS" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

/* tests/tb_ifu.sv */
`timescale 1ns/10ps
`include "ifu_params.svh"

module tb_ifu;

    localparam int  MEM_WORDS  = 1024;
    localparam int  N_FIRST    = 2;
    localparam int  N_STREAM   = 400;
    localparam int  N_STALL    = 200;
    localparam int  TOTAL_INST = N_FIRST + N_STREAM + N_STALL;
    // 40 cycles of 100 ns per expected instruction
    localparam real TIMEOUT_NS = 40.0 * TOTAL_INST * 100.0;

    logic                 clk;
    logic                 fifo_rst;
    ifu_pkg::apb_rsp_t    apb_rsp;
    logic                 d_ena;
    logic                 redirect;
    logic [31:0]          redirect_pc;
    ifu_pkg::apb_req_t    apb_req;
    ifu_pkg::issue_slot_t issue0;
    ifu_pkg::issue_slot_t issue1;
    logic                 in_delay_slot;

    logic [31:0] mem [MEM_WORDS];
    int          errors;
    int          consumed;
    int          transfers;
    int          wait_left;
    int          redir_cnt;
    // reference model state
    logic [31:0] exp_pc;
    logic        ds_pending;
    logic        jump_pending;
    logic [31:0] jump_target;
    logic        seen_first;
    // values seen at the previous falling edge
    ifu_pkg::apb_req_t    prev_req;
    logic                 prev_pready;
    ifu_pkg::issue_slot_t prev_i0;
    ifu_pkg::issue_slot_t prev_i1;
    logic                 prev_de;
    logic                 prev_rd;

    ifu_top u_dut (
        .clk           (clk),
        .fifo_rst      (fifo_rst),
        .apb_rsp       (apb_rsp),
        .d_ena         (d_ena),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .apb_req       (apb_req),
        .issue0        (issue0),
        .issue1        (issue1),
        .in_delay_slot (in_delay_slot)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // own copy of the branch and jump rule
    function automatic logic is_cti_word(input logic [31:0] w);
        logic [5:0] op;
        op = w[31:26];
        if (op >= 6'd1 && op <= 6'd7) begin
            return 1'b1;
        end
        return (op == 6'd0) && (w[5:0] == 6'b001000 || w[5:0] == 6'b001001);
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return mem[addr[11:2]];
    endfunction

    // roughly a quarter control flow, never a branch in a delay slot
    task automatic fill_memory();
        logic [31:0] r;
        for (int i = 0; i < MEM_WORDS; i++) begin
            r = $urandom;
            if (r[1:0] == 2'b00) begin
                if (r[4:2] == 3'd0) begin
                    mem[i] = {6'd0, r[25:6], 6'b001000 | {5'd0, r[5]}};
                end else begin
                    mem[i] = {3'b000, r[4:2], r[31:6]};
                end
            end else begin
                mem[i] = {6'd8 + 6'(r[31:26] % 56), r[25:0]};
            end
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (is_cti_word(mem[i]) && is_cti_word(mem[(i + 1) % MEM_WORDS])) begin
                mem[(i + 1) % MEM_WORDS][31:26] = 6'd9;
            end
        end
    endtask

    // apb slave, random wait states per word
    task automatic drive_memory();
        apb_rsp.pready = 1'b0;
        if (apb_req.psel && !apb_req.penable) begin
            wait_left = int'($urandom % 4);
        end else if (apb_req.psel && apb_req.penable) begin
            if (wait_left == 0) begin
                apb_rsp.pready = 1'b1;
                apb_rsp.prdata = mem_word(apb_req.paddr);
                transfers++;
            end else begin
                wait_left--;
            end
        end
    endtask

    task automatic check_apb();
        if (apb_req.psel && !seen_first) begin
            assert (apb_req.paddr == `IFU_RESET_PC) else begin
                $display("Mismatch paddr: got %h expected %h", apb_req.paddr, `IFU_RESET_PC);
                errors++;
            end
            seen_first = 1'b1;
        end
        assert (!apb_req.penable || apb_req.psel) else begin
            $display("penable high without psel");
            errors++;
        end
        // access follows a setup or an access still waiting for pready
        assert (!apb_req.penable || (prev_req.psel && !prev_req.penable)
                || (prev_req.penable && !prev_pready)) else begin
            $display("penable high without a setup cycle before it");
            errors++;
        end
        // transfer in progress must stay put until pready
        if (prev_req.psel && !(prev_req.penable && prev_pready)) begin
            assert (apb_req.psel && apb_req.penable) else begin
                $display("apb transfer left before completion");
                errors++;
            end
            assert (apb_req.paddr == prev_req.paddr) else begin
                $display("Mismatch paddr: got %h expected %h", apb_req.paddr, prev_req.paddr);
                errors++;
            end
        end
    endtask

    // one consumed slot against the model
    task automatic check_slot(input string name, input ifu_pkg::issue_slot_t s);
        assert (s.pc == exp_pc) else begin
            $display("Mismatch %s.pc: got %h expected %h", name, s.pc, exp_pc);
            errors++;
        end
        assert (s.inst == mem_word(exp_pc)) else begin
            $display("Mismatch %s.inst: got %h expected %h", name, s.inst, mem_word(exp_pc));
            errors++;
        end
    endtask

    // everything here is what the coming rising edge will take
    task automatic check_cycle();
        check_apb();
        // stalled outputs stay put unless flushed
        if (!prev_de && !prev_rd && prev_i0.valid) begin
            assert (issue0 == prev_i0) else begin
                $display("Mismatch issue0: got %h expected %h", issue0, prev_i0);
                errors++;
            end
            if (prev_i1.valid) begin
                assert (issue1 == prev_i1) else begin
                    $display("Mismatch issue1: got %h expected %h", issue1, prev_i1);
                    errors++;
                end
            end
        end
        assert (!issue1.valid || issue0.valid) else begin
            $display("issue1 valid without issue0");
            errors++;
        end
        if (d_ena && issue0.valid) begin
            check_slot("issue0", issue0);
            assert (in_delay_slot == ds_pending) else begin
                $display("Mismatch in_delay_slot: got %h expected %h", in_delay_slot, ds_pending);
                errors++;
            end
            if (jump_pending) begin
                // held delay slot done, redirected stream next
                exp_pc       = jump_target;
                jump_pending = 1'b0;
            end else begin
                exp_pc = exp_pc + 32'd4;
            end
            consumed++;
            ds_pending = is_cti_word(issue0.inst) && !issue1.valid;
            if (ds_pending && redir_cnt == 0 && $urandom % 2 == 0) begin
                redir_cnt = 1 + int'($urandom % 4);
            end
            if (issue1.valid) begin
                assert (!is_cti_word(issue0.inst)) else begin
                    $display("issue1 paired with a branch or jump in issue0");
                    errors++;
                end
                check_slot("issue1", issue1);
                exp_pc = exp_pc + 32'd4;
                consumed++;
            end
        end
        if (redirect) begin
            if (ds_pending) begin
                jump_pending = 1'b1;
                jump_target  = redirect_pc;
            end else begin
                exp_pc = redirect_pc;
            end
        end
        prev_req    = apb_req;
        prev_pready = apb_rsp.pready;
        prev_i0     = issue0;
        prev_i1     = issue1;
        prev_de     = d_ena;
        prev_rd     = redirect;
    endtask

    task automatic run_cycle(input int stall_pct);
        @(posedge clk);
        #10;
        drive_memory();
        d_ena    = (int'($urandom % 100) >= stall_pct);
        redirect = 1'b0;
        if (redir_cnt > 0) begin
            redir_cnt--;
            if (redir_cnt == 0) begin
                redirect    = 1'b1;
                redirect_pc = {20'hbfc00, 10'($urandom % MEM_WORDS), 2'b00};
                // a branch is not taken at the same edge as its own flush
                if (issue0.valid && is_cti_word(issue0.inst)) begin
                    d_ena = 1'b0;
                end
            end
        end
        @(negedge clk);
        check_cycle();
    endtask

    task automatic run_test(input string name, input int target, input int stall_pct);
        int start_err;
        int start_cnt;
        start_err = errors;
        start_cnt = consumed;
        while (consumed - start_cnt < target) begin
            run_cycle(stall_pct);
        end
        $display("test %s: %0d instructions, %0d errors", name, consumed - start_cnt,
                 errors - start_err);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired, DUT stopped issuing instructions");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int rst_err;
        fifo_rst     = 1'b1;
        apb_rsp      = '0;
        d_ena        = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        errors       = 0;
        consumed     = 0;
        transfers    = 0;
        wait_left    = 0;
        redir_cnt    = 0;
        exp_pc       = `IFU_RESET_PC;
        ds_pending   = 1'b0;
        jump_pending = 1'b0;
        jump_target  = '0;
        seen_first   = 1'b0;
        prev_req     = '0;
        prev_pready  = 1'b0;
        prev_i0      = '0;
        prev_i1      = '0;
        prev_de      = 1'b0;
        prev_rd      = 1'b0;
        void'($urandom(9));
        fill_memory();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_err = errors;
        assert (!issue0.valid && !issue1.valid && !in_delay_slot) else begin
            $display("issue outputs active during reset");
            errors++;
        end
        assert (!apb_req.psel && !apb_req.penable) else begin
            $display("apb request active during reset");
            errors++;
        end
        $display("test reset: %0d errors", errors - rst_err);
        @(posedge clk);
        #10;
        fifo_rst = 1'b0;
        @(negedge clk);
        check_cycle();
        run_test("first_fetch", N_FIRST, 0);
        run_test("random_stream", N_STREAM, 30);
        run_test("heavy_stall", N_STALL, 80);
        $display("consumed %0d, transfers %0d, errors %0d", consumed, transfers, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
